//--- hdl/vseq_pkg.sv
/*
  Vector sequencer shared definitions
  Widths of IDs, registers, vector length and addresses, the op and unit
  encodings, the instruction word layout and small op helpers
*/
package vseq_pkg;

  // Instructions in flight, sets the ID width
  localparam int unsigned NrVInsn = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0]                 vreg_t;
  typedef logic [7:0]                 vl_t;
  // 0..3 for 8, 16, 32, 64 bit elements
  typedef logic [1:0]                 ew_t;
  typedef logic [31:0]                addr_t;
  // One bit per instruction ID
  typedef logic [NrVInsn-1:0]         vinsn_set_t;

  // Mask lives in v0
  localparam vreg_t VMASK = 5'd0;

  typedef enum logic [3:0] {
    VADD = 4'd0,
    VSUB = 4'd1,
    VXOR = 4'd2,
    VAND = 4'd3,
    VLE  = 4'd4,
    VSE  = 4'd5
  } vinsn_op_e;

  typedef enum logic [1:0] {
    VFU_ALU   = 2'd0,
    VFU_LOAD  = 2'd1,
    VFU_STORE = 2'd2
  } vfu_e;

  // Instruction word fields, LSB positions
  localparam int unsigned OpLsb     = 0;
  localparam int unsigned VmBit     = 4;
  localparam int unsigned VdLsb     = 5;
  localparam int unsigned Vs1Lsb    = 10;
  localparam int unsigned Vs2Lsb    = 15;
  localparam int unsigned EwLsb     = 20;
  localparam int unsigned VlLsb     = 22;
  localparam int unsigned UseVs1Bit = 30;
  localparam int unsigned UseVs2Bit = 31;

  function automatic logic is_load(vinsn_op_e op);
    return op == VLE;
  endfunction

  function automatic logic is_store(vinsn_op_e op);
    return op == VSE;
  endfunction

  // Unit kind that executes an op
  function automatic vfu_e op_to_vfu(vinsn_op_e op);
    if (is_load(op)) return VFU_LOAD;
    if (is_store(op)) return VFU_STORE;
    return VFU_ALU;
  endfunction

endpackage

//--- hdl/vinsn_decoder.sv
/*
  Instruction decoder
  One-entry register stage with valid/ready on both sides, splits the
  32-bit instruction word into operand fields
*/
`timescale 1ns/1ps

module vinsn_decoder import vseq_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] instr_i,
  input  addr_t       addr_i,
  input  logic        instr_valid_i,
  output logic        instr_ready_o,
  output logic        dec_valid_o,
  input  logic        dec_ready_i,
  output vinsn_op_e   dec_op_o,
  output logic        dec_vm_o,
  output vreg_t       dec_vd_o,
  output vreg_t       dec_vs1_o,
  output vreg_t       dec_vs2_o,
  output logic        dec_use_vd_o,
  output logic        dec_use_vs1_o,
  output logic        dec_use_vs2_o,
  output ew_t         dec_ew_o,
  output vl_t         dec_vl_o,
  output addr_t       dec_addr_o
);

  logic [3:0] op_raw;
  vinsn_op_e  op;
  logic       accept;

  assign op_raw = instr_i[OpLsb +: 4];
  // Undefined encodings fall back to VADD
  assign op = (op_raw <= VSE) ? vinsn_op_e'(op_raw) : VADD;

  // Free slot, or the slot drains this cycle
  assign instr_ready_o = !dec_valid_o || dec_ready_i;
  assign accept        = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else if (instr_ready_o) begin
      dec_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_fields
    if (accept) begin
      dec_op_o      <= op;
      dec_vm_o      <= instr_i[VmBit];
      dec_vd_o      <= instr_i[VdLsb +: 5];
      dec_vs1_o     <= instr_i[Vs1Lsb +: 5];
      dec_vs2_o     <= instr_i[Vs2Lsb +: 5];
      // Store data sits in the vd field, nothing is written
      dec_use_vd_o  <= !is_store(op);
      dec_use_vs1_o <= instr_i[UseVs1Bit];
      dec_use_vs2_o <= instr_i[UseVs2Bit];
      dec_ew_o      <= instr_i[EwLsb +: 2];
      dec_vl_o      <= instr_i[VlLsb +: 8];
      dec_addr_o    <= addr_i;
    end
  end

  a_op_defined : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> op_raw <= VSE)
    else $error("undefined op 0x%0h", op_raw);

endmodule

//--- hdl/vinsn_sequencer.sv
/*
  Vector instruction sequencer
  Allocates IDs, tracks which lanes still run each ID, keeps reader and
  writer lists per register for RAW, WAR and WAW hazards and broadcasts
  each instruction to the lanes. Loads and stores hold the input side
  until the address checker answers
*/
`timescale 1ns/1ps

module vinsn_sequencer import vseq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Decoded request
  input  logic                     dec_valid_i,
  output logic                     dec_ready_o,
  input  vinsn_op_e                dec_op_i,
  input  logic                     dec_vm_i,
  input  vreg_t                    dec_vd_i,
  input  vreg_t                    dec_vs1_i,
  input  vreg_t                    dec_vs2_i,
  input  logic                     dec_use_vd_i,
  input  logic                     dec_use_vs1_i,
  input  logic                     dec_use_vs2_i,
  input  ew_t                      dec_ew_i,
  input  vl_t                      dec_vl_i,
  input  addr_t                    dec_addr_i,
  // Broadcast to lanes and address checker
  output logic                     pe_valid_o,
  output vid_t                     pe_id_o,
  output vinsn_op_e                pe_op_o,
  output vl_t                      pe_vl_o,
  output ew_t                      pe_ew_o,
  output addr_t                    pe_addr_o,
  output vinsn_set_t               pe_hazard_o,
  output vinsn_set_t               running_o,
  input  logic       [NrLanes-1:0] pe_ready_i,
  input  logic       [NrLanes-1:0] lane_done_i,
  input  vid_t       [NrLanes-1:0] lane_done_id_i,
  // Address checker answer
  input  logic                     addr_ack_i,
  input  logic                     addr_error_i,
  output vinsn_set_t               retire_o,
  output logic                     resp_valid_o,
  output logic                     resp_error_o
);

  // Slots 0..31 are the vector registers, slot 32 tracks mask use
  localparam int unsigned MaskSlot = 32;
  localparam int unsigned NrSlots  = 33;

  typedef enum logic {IDLE, WAIT} state_e;
  state_e state_d, state_q;

  vinsn_set_t [NrLanes-1:0] lane_run_d, lane_run_q, lane_left;
  vinsn_set_t               run_all, run_left, hazard_d;
  vid_t                     next_id;
  logic                     id_full, issue, store_src;

  vid_t [NrSlots-1:0] rd_id_d, rd_id_q, wr_id_d, wr_id_q;
  logic [NrSlots-1:0] rd_vld_d, rd_vld_q, wr_vld_d, wr_vld_q;

  // Running set, and what is left after this cycle's done pulses
  always_comb begin : p_running
    run_all  = '0;
    run_left = '0;
    for (int l = 0; l < NrLanes; l++) begin
      lane_left[l] = lane_run_q[l];
      if (lane_done_i[l]) begin
        lane_left[l][lane_done_id_i[l]] = 1'b0;
      end
      run_all  |= lane_run_q[l];
      run_left |= lane_left[l];
    end
  end

  // Lowest free ID
  always_comb begin : p_next_id
    next_id = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!run_all[i]) next_id = vid_t'(i);
    end
  end

  assign id_full   = &run_all;
  assign running_o = run_all;
  // A store reads its data from the vd field
  assign store_src = is_store(dec_op_i);

  always_comb begin : p_sequencer
    state_d      = state_q;
    lane_run_d   = lane_left;
    hazard_d     = '0;
    dec_ready_o  = 1'b0;
    issue        = 1'b0;
    resp_valid_o = 1'b0;
    resp_error_o = 1'b0;
    rd_id_d      = rd_id_q;
    wr_id_d      = wr_id_q;
    // Forget entries whose owner has retired
    for (int v = 0; v < NrSlots; v++) begin
      rd_vld_d[v] = rd_vld_q[v] & run_all[rd_id_q[v]];
      wr_vld_d[v] = wr_vld_q[v] & run_all[wr_id_q[v]];
    end

    case (state_q)
      IDLE: begin
        dec_ready_o = &pe_ready_i && !id_full;
        issue       = dec_valid_i && dec_ready_o;
        if (issue) begin
          for (int l = 0; l < NrLanes; l++) begin
            lane_run_d[l][next_id] = 1'b1;
          end
          // RAW on sources and mask
          if (dec_use_vs1_i) hazard_d[wr_id_d[dec_vs1_i]] |= wr_vld_d[dec_vs1_i];
          if (dec_use_vs2_i) hazard_d[wr_id_d[dec_vs2_i]] |= wr_vld_d[dec_vs2_i];
          if (store_src) hazard_d[wr_id_d[dec_vd_i]] |= wr_vld_d[dec_vd_i];
          if (dec_vm_i) hazard_d[wr_id_d[MaskSlot]] |= wr_vld_d[MaskSlot];
          if (dec_use_vd_i) begin
            // WAR, mask readers count when v0 is overwritten
            hazard_d[rd_id_d[dec_vd_i]] |= rd_vld_d[dec_vd_i];
            if (dec_vd_i == VMASK) hazard_d[rd_id_d[MaskSlot]] |= rd_vld_d[MaskSlot];
            // WAW
            hazard_d[wr_id_d[dec_vd_i]] |= wr_vld_d[dec_vd_i];
            wr_id_d[dec_vd_i]  = next_id;
            wr_vld_d[dec_vd_i] = 1'b1;
            if (dec_vd_i == VMASK) begin
              wr_id_d[MaskSlot]  = next_id;
              wr_vld_d[MaskSlot] = 1'b1;
            end
          end
          // Record this instruction as latest reader
          if (dec_use_vs1_i) begin
            rd_id_d[dec_vs1_i]  = next_id;
            rd_vld_d[dec_vs1_i] = 1'b1;
          end
          if (dec_use_vs2_i) begin
            rd_id_d[dec_vs2_i]  = next_id;
            rd_vld_d[dec_vs2_i] = 1'b1;
          end
          if (store_src) begin
            rd_id_d[dec_vd_i]  = next_id;
            rd_vld_d[dec_vd_i] = 1'b1;
          end
          if (dec_vm_i) begin
            rd_id_d[MaskSlot]  = next_id;
            rd_vld_d[MaskSlot] = 1'b1;
          end
          // Memory ops wait for the address check
          if (is_load(dec_op_i) || is_store(dec_op_i)) state_d = WAIT;
        end
      end
      WAIT: begin
        if (addr_ack_i) begin
          resp_valid_o = 1'b1;
          resp_error_o = addr_error_i;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q    <= IDLE;
      lane_run_q <= '0;
      rd_vld_q   <= '0;
      wr_vld_q   <= '0;
      pe_valid_o <= 1'b0;
      retire_o   <= '0;
    end else begin
      state_q    <= state_d;
      lane_run_q <= lane_run_d;
      rd_vld_q   <= rd_vld_d;
      wr_vld_q   <= wr_vld_d;
      pe_valid_o <= issue;
      // IDs whose last lane finished this cycle
      retire_o   <= run_all & ~run_left;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    rd_id_q <= rd_id_d;
    wr_id_q <= wr_id_d;
    if (issue) begin
      pe_id_o     <= next_id;
      pe_op_o     <= dec_op_i;
      pe_vl_o     <= dec_vl_i;
      pe_ew_o     <= dec_ew_i;
      pe_addr_o   <= dec_addr_i;
      pe_hazard_o <= hazard_d;
    end
  end

  // Lanes finish only IDs they still run
  // An ID reissued while a lane still held it ends in a second done
  for (genvar l = 0; l < NrLanes; l++) begin : g_done_chk
    a_id_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_done_i[l] |-> lane_run_q[l][lane_done_id_i[l]])
      else $error("lane %0d done for ID %0d that is not running", l, lane_done_id_i[l]);
  end

  a_ack_in_wait : assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_ack_i |-> state_q == WAIT)
    else $error("address ack outside WAIT");

endmodule

//--- hdl/vector_lane.sv
/*
  Vector lane
  Queues up to two instructions, holds the head until every producer it
  depends on has retired, then runs for its share of the vector length
  and pulses done with the instruction ID
*/
`timescale 1ns/1ps

module vector_lane import vseq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       pe_valid_i,
  input  vid_t       pe_id_i,
  input  vl_t        pe_vl_i,
  input  vinsn_set_t pe_hazard_i,
  input  vinsn_set_t running_i,
  output logic       pe_ready_o,
  output logic       done_o,
  output vid_t       done_id_o
);

  vid_t       [1:0] q_id_q;
  vl_t        [1:0] q_cnt_q;
  vinsn_set_t [1:0] q_haz_q;
  logic             wr_ptr_q, rd_ptr_q;
  logic       [1:0] fill_d, fill_q;
  logic             busy_q, start;
  vl_t              cnt_q, share;
  vid_t             cur_id_q;

  // Elements of this lane, ceil(vl / NrLanes) and at least one
  always_comb begin : p_share
    share = vl_t'((32'(pe_vl_i) + NrLanes - 1) / NrLanes);
    if (share == '0) share = vl_t'(1);
  end

  // Head starts once no producer is still running
  assign start = !busy_q && (fill_q != 2'd0) && ((q_haz_q[rd_ptr_q] & running_i) == '0);

  assign fill_d = fill_q + 2'(pe_valid_i) - 2'(start);
  // Broadcasts arrive a cycle after ready, so look at next fill level
  assign pe_ready_o = fill_d < 2'd2;

  assign done_o    = busy_q && (cnt_q == vl_t'(1));
  assign done_id_o = cur_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= 2'd0;
      busy_q   <= 1'b0;
    end else begin
      fill_q <= fill_d;
      if (pe_valid_i) wr_ptr_q <= !wr_ptr_q;
      if (start) begin
        rd_ptr_q <= !rd_ptr_q;
        busy_q   <= 1'b1;
      end else if (done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    // Retired producers drop out of the wait sets
    for (int i = 0; i < 2; i++) begin
      q_haz_q[i] <= q_haz_q[i] & running_i;
    end
    if (pe_valid_i) begin
      q_id_q[wr_ptr_q]  <= pe_id_i;
      q_cnt_q[wr_ptr_q] <= share;
      q_haz_q[wr_ptr_q] <= pe_hazard_i & running_i;
    end
    if (start) begin
      cur_id_q <= q_id_q[rd_ptr_q];
      cnt_q    <= q_cnt_q[rd_ptr_q];
    end else if (busy_q) begin
      cnt_q <= cnt_q - vl_t'(1);
    end
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_valid_i |-> fill_q != 2'd2)
    else $error("lane queue written while full");

endmodule

//--- hdl/vaddr_checker.sv
/*
  Load/store address checker
  Two-stage pipeline: computes the byte span, then flags misaligned
  addresses and accesses that cross a 4 KiB page
*/
`timescale 1ns/1ps

module vaddr_checker import vseq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      pe_valid_i,
  input  vinsn_op_e pe_op_i,
  input  vl_t       pe_vl_i,
  input  ew_t       pe_ew_i,
  input  addr_t     pe_addr_i,
  output logic      addr_ack_o,
  output logic      addr_error_o
);

  logic        s1_valid_q, s1_empty_q, misaligned, crossing;
  logic [11:0] s1_span_q;
  addr_t       s1_addr_q, last_byte;
  ew_t         s1_ew_q;

  // Low address bits must be zero for the element size
  assign misaligned = (4'(s1_addr_q[2:0]) & ((4'd1 << s1_ew_q) - 4'd1)) != 4'd0;
  assign last_byte  = s1_addr_q + addr_t'(s1_span_q) - addr_t'(1);
  assign crossing   = last_byte[31:12] != s1_addr_q[31:12];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      s1_valid_q   <= 1'b0;
      addr_ack_o   <= 1'b0;
      addr_error_o <= 1'b0;
    end else begin
      s1_valid_q   <= pe_valid_i && (op_to_vfu(pe_op_i) != VFU_ALU);
      addr_ack_o   <= s1_valid_q;
      // Empty access touches nothing
      addr_error_o <= s1_valid_q && !s1_empty_q && (misaligned || crossing);
    end
  end

  always_ff @(posedge clk_i) begin : p_stage1
    s1_span_q  <= 12'(pe_vl_i) << pe_ew_i;
    s1_addr_q  <= pe_addr_i;
    s1_ew_q    <= pe_ew_i;
    s1_empty_q <= pe_vl_i == '0;
  end

endmodule

//--- hdl/vseq_top.sv
/*
  Vector sequencer subsystem top
  Decoder, sequencer, a row of lanes and the address checker
*/
`timescale 1ns/1ps

module vseq_top import vseq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] instr_i,
  input  addr_t       addr_i,
  input  logic        instr_valid_i,
  output logic        instr_ready_o,
  output logic        issue_valid_o,
  output vid_t        issue_id_o,
  output vinsn_set_t  retire_o,
  output logic        resp_valid_o,
  output logic        resp_error_o
);

  logic                     dec_valid, dec_ready, dec_vm;
  logic                     dec_use_vd, dec_use_vs1, dec_use_vs2;
  vinsn_op_e                dec_op, pe_op;
  vreg_t                    dec_vd, dec_vs1, dec_vs2;
  ew_t                      dec_ew, pe_ew;
  vl_t                      dec_vl, pe_vl;
  addr_t                    dec_addr, pe_addr;
  logic                     pe_valid, addr_ack, addr_error;
  vid_t                     pe_id;
  vinsn_set_t               pe_hazard, running;
  logic       [NrLanes-1:0] pe_ready, lane_done;
  vid_t       [NrLanes-1:0] lane_done_id;

  assign issue_valid_o = pe_valid;
  assign issue_id_o    = pe_id;

  vinsn_decoder i_decoder (
    .clk_i, .rst_ni, .instr_i, .addr_i, .instr_valid_i, .instr_ready_o,
    .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_op_o(dec_op),
    .dec_vm_o(dec_vm), .dec_vd_o(dec_vd), .dec_vs1_o(dec_vs1), .dec_vs2_o(dec_vs2),
    .dec_use_vd_o(dec_use_vd), .dec_use_vs1_o(dec_use_vs1),
    .dec_use_vs2_o(dec_use_vs2), .dec_ew_o(dec_ew), .dec_vl_o(dec_vl),
    .dec_addr_o(dec_addr)
  );

  vinsn_sequencer #(.NrLanes(NrLanes)) i_sequencer (
    .clk_i, .rst_ni,
    .dec_valid_i(dec_valid), .dec_ready_o(dec_ready), .dec_op_i(dec_op),
    .dec_vm_i(dec_vm), .dec_vd_i(dec_vd), .dec_vs1_i(dec_vs1), .dec_vs2_i(dec_vs2),
    .dec_use_vd_i(dec_use_vd), .dec_use_vs1_i(dec_use_vs1),
    .dec_use_vs2_i(dec_use_vs2), .dec_ew_i(dec_ew), .dec_vl_i(dec_vl),
    .dec_addr_i(dec_addr),
    .pe_valid_o(pe_valid), .pe_id_o(pe_id), .pe_op_o(pe_op), .pe_vl_o(pe_vl),
    .pe_ew_o(pe_ew), .pe_addr_o(pe_addr), .pe_hazard_o(pe_hazard),
    .running_o(running), .pe_ready_i(pe_ready), .lane_done_i(lane_done),
    .lane_done_id_i(lane_done_id), .addr_ack_i(addr_ack), .addr_error_i(addr_error),
    .retire_o, .resp_valid_o, .resp_error_o
  );

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    vector_lane #(.NrLanes(NrLanes)) i_lane (
      .clk_i, .rst_ni,
      .pe_valid_i(pe_valid), .pe_id_i(pe_id), .pe_vl_i(pe_vl),
      .pe_hazard_i(pe_hazard), .running_i(running), .pe_ready_o(pe_ready[l]),
      .done_o(lane_done[l]), .done_id_o(lane_done_id[l])
    );
  end

  vaddr_checker i_addr_checker (
    .clk_i, .rst_ni,
    .pe_valid_i(pe_valid), .pe_op_i(pe_op), .pe_vl_i(pe_vl), .pe_ew_i(pe_ew),
    .pe_addr_i(pe_addr), .addr_ack_o(addr_ack), .addr_error_o(addr_error)
  );

endmodule

//--- dv/tb_vseq.sv
/*
  Testbench for the vector sequencer subsystem
  Sends long, short, memory and random dependent instruction streams,
  shadows the reader/writer lists and checks issue, hazard order,
  retirement and address responses with concurrent assertions
*/
`timescale 1ns/1ps

module tb_vseq import vseq_pkg::*; ();

  localparam int ClkPeriod = 8;
  localparam int LongN     = 9;
  localparam int ShortN    = 12;
  localparam int MemN      = 8;
  localparam int RandN     = 64;
  localparam int NumInsn   = LongN + ShortN + MemN + RandN;
  localparam int MaskSlot  = 32;
  localparam logic [31:0] Seed = 32'ha4d85eb4;

  logic       clk_i, rst_ni, instr_valid_i, instr_ready_o;
  logic [31:0] instr_i;
  addr_t      addr_i;
  logic       issue_valid_o, resp_valid_o, resp_error_o;
  vid_t       issue_id_o;
  vinsn_set_t retire_o;

  // Sent but not yet issued, in order
  logic [31:0] sent_q[$];
  addr_t       addr_q[$];
  int          sent_cnt, issues_seen, retires_seen, errors, max_running;
  logic        b2b_seen, prev_issue;

  // Shadow of the hazard lists and running set
  vinsn_set_t  run_model, dep_bad;
  vinsn_set_t  pred [NrVInsn];
  vid_t        rd_id [33];
  vid_t        wr_id [33];
  logic [32:0] rd_v, wr_v;
  // Expected response one and two cycles after a memory issue
  logic        resp_exp1, resp_exp2, err_exp1, err_exp2;

  vseq_top #(.NrLanes(4)) dut (
    .clk_i, .rst_ni, .instr_i, .addr_i, .instr_valid_i, .instr_ready_o,
    .issue_valid_o, .issue_id_o, .retire_o, .resp_valid_o, .resp_error_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Word layout from LSB: op, vm, vd, vs1, vs2, ew, vl, use_vs1, use_vs2
  function automatic logic [31:0] pack_insn(input logic [3:0] op, input logic vm,
                                            input logic [4:0] vd, input logic [4:0] vs1,
                                            input logic [4:0] vs2, input logic [1:0] ew,
                                            input logic [7:0] vl, input logic u1,
                                            input logic u2);
    return {u2, u1, vl, ew, vs2, vs1, vd, vm, op};
  endfunction

  // Hold valid until ready, transfer lands on the next rising edge
  task automatic send(input logic [31:0] w, input addr_t a);
    @(negedge clk_i);
    instr_i       = w;
    addr_i        = a;
    instr_valid_i = 1'b1;
    while (!instr_ready_o) @(negedge clk_i);
    sent_q.push_back(w);
    addr_q.push_back(a);
    sent_cnt++;
  endtask

  // Memory op with an ALU op right behind it
  task automatic mem_pair(input logic [3:0] op, input logic [1:0] ew, input logic [7:0] vl,
                          input addr_t a);
    send(pack_insn(op, 1'b0, 5'd9, 5'd0, 5'd0, ew, vl, 1'b0, 1'b0), a);
    send(pack_insn(VXOR, 1'b0, 5'd12, 5'd0, 5'd0, 2'd0, 8'd3, 1'b0, 1'b0), '0);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    while (sent_q.size() != 0 || run_model != '0) @(negedge clk_i);
  endtask

  task automatic print_summary();
    $display("Summary: %0d sent, %0d issued, %0d retired, %0d errors",
             sent_cnt, issues_seen, retires_seen, errors);
  endtask

  always @(posedge clk_i) begin : p_model
    logic [31:0] w, span, last;
    addr_t       a;
    logic [4:0]  vd;
    logic        st;
    logic [32:0] rd_slots;
    vinsn_set_t  p;
    if (!rst_ni) begin
      run_model = '0;
      rd_v      = '0;
      wr_v      = '0;
      resp_exp1 = 1'b0;
      resp_exp2 = 1'b0;
      err_exp1  = 1'b0;
      err_exp2  = 1'b0;
      for (int i = 0; i < NrVInsn; i++) pred[i] = '0;
    end else begin
      resp_exp2 = resp_exp1;
      err_exp2  = err_exp1;
      resp_exp1 = 1'b0;
      if (issue_valid_o && prev_issue) b2b_seen = 1'b1;
      prev_issue = issue_valid_o;
      if (issue_valid_o && sent_q.size() == 0) begin
        errors++;
        $display("Issue seen with no instruction outstanding");
      end else if (issue_valid_o) begin
        w  = sent_q.pop_front();
        a  = addr_q.pop_front();
        vd = w[9:5];
        st = w[3:0] == VSE;
        p  = '0;
        // Registers read: sources, store data and the mask
        rd_slots = '0;
        if (w[30]) rd_slots[w[14:10]] = 1'b1;
        if (w[31]) rd_slots[w[19:15]] = 1'b1;
        if (st) rd_slots[vd] = 1'b1;
        if (w[4]) rd_slots[MaskSlot] = 1'b1;
        // RAW on the latest writer
        for (int s = 0; s < 33; s++) begin
          if (rd_slots[s] && wr_v[s]) p[wr_id[s]] = 1'b1;
        end
        if (!st) begin
          // WAR on the latest reader, WAW on the latest writer
          if (rd_v[vd]) p[rd_id[vd]] = 1'b1;
          if (wr_v[vd]) p[wr_id[vd]] = 1'b1;
          if (vd == VMASK && rd_v[MaskSlot]) p[rd_id[MaskSlot]] = 1'b1;
          wr_id[vd] = issue_id_o;
          wr_v[vd]  = 1'b1;
          if (vd == VMASK) begin
            wr_id[MaskSlot] = issue_id_o;
            wr_v[MaskSlot]  = 1'b1;
          end
        end
        for (int s = 0; s < 33; s++) begin
          if (rd_slots[s]) begin
            rd_id[s] = issue_id_o;
            rd_v[s]  = 1'b1;
          end
        end
        pred[issue_id_o]      = p;
        run_model[issue_id_o] = 1'b1;
        issues_seen++;
        if (w[3:0] == VLE || st) begin
          // Misaligned, or last byte in another 4 KiB page, unless empty
          span      = 32'(w[29:22]) << w[21:20];
          last      = a + span - 32'd1;
          resp_exp1 = 1'b1;
          err_exp1  = (w[29:22] != 8'd0) &&
                      (((a & ((32'd1 << w[21:20]) - 32'd1)) != 0) || last[31:12] != a[31:12]);
        end
      end
      if ($countones(run_model) > max_running) max_running = $countones(run_model);
      // Retirements after issue, an ID retiring now still counted as a producer
      for (int i = 0; i < NrVInsn; i++) begin
        if (retire_o[i]) begin
          run_model[i] = 1'b0;
          retires_seen++;
          for (int s = 0; s < 33; s++) begin
            if (rd_id[s] == vid_t'(i)) rd_v[s] = 1'b0;
            if (wr_id[s] == vid_t'(i)) wr_v[s] = 1'b0;
          end
          // Retired producer no longer holds back anyone, its ID may be reused
          for (int j = 0; j < NrVInsn; j++) pred[j][i] = 1'b0;
        end
      end
    end
  end

  // Consumers retiring while a producer is still running
  always_comb begin : p_dep_check
    for (int i = 0; i < NrVInsn; i++) begin
      dep_bad[i] = retire_o[i] && ((pred[i] & run_model & ~retire_o) != '0);
    end
  end

  a_reset_state : assert property (@(posedge clk_i) $rose(rst_ni) |->
    !issue_valid_o && retire_o == '0 && !resp_valid_o && instr_ready_o)
    else begin
      errors++;
      $display("Fail after reset issue_valid_o=%h retire_o=%h resp_valid_o=%h instr_ready_o=%h",
               $sampled(issue_valid_o), $sampled(retire_o), $sampled(resp_valid_o),
               $sampled(instr_ready_o));
    end

  a_dep_order : assert property (@(posedge clk_i) disable iff (!rst_ni) dep_bad == '0)
    else begin
      errors++;
      $display("Fail retire_o=%h ahead of a producer, consumers %h",
               $sampled(retire_o), $sampled(dep_bad));
    end

  a_id_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> !run_model[issue_id_o])
    else begin
      errors++;
      $display("Fail issue_id_o=%h still running, running=%h",
               $sampled(issue_id_o), $sampled(run_model));
    end

  a_retire_once : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (retire_o & ~run_model) == '0)
    else begin
      errors++;
      $display("Fail retire_o=%h running=%h", $sampled(retire_o), $sampled(run_model));
    end

  a_resp_timing : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o == resp_exp2)
    else begin
      errors++;
      $display("Fail resp_valid_o=%h expected %h", $sampled(resp_valid_o), $sampled(resp_exp2));
    end

  a_resp_error : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && resp_exp2 |-> resp_error_o == err_exp2)
    else begin
      errors++;
      $display("Fail resp_error_o=%h expected %h", $sampled(resp_error_o), $sampled(err_exp2));
    end

  // Input side blocked while a load or store waits for its check
  a_mem_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_exp1 || resp_exp2) && instr_valid_i |-> !instr_ready_o)
    else begin
      errors++;
      $display("Fail instr_ready_o=%h expected 0", $sampled(instr_ready_o));
    end

  initial begin : p_watchdog
    #(NumInsn * 200 * ClkPeriod);
    errors++;
    $display("Watchdog expired before every instruction retired");
    print_summary();
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : p_stim
    logic [3:0] op;
    int         r;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    addr_i        = '0;
    sent_cnt      = 0;
    issues_seen   = 0;
    retires_seen  = 0;
    errors        = 0;
    max_running   = 0;
    b2b_seen      = 1'b0;
    prev_issue    = 1'b0;
    void'($urandom(Seed));
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // Long independent ops back up the lane queues
    for (int i = 0; i < LongN; i++) begin
      send(pack_insn(VADD, 1'b0, 5'(8 + i), 5'd0, 5'd0, 2'd2, 8'd255, 1'b0, 1'b0), '0);
    end
    wait_drain();
    // Short independent ops
    for (int i = 0; i < ShortN; i++) begin
      send(pack_insn(4'(i % 4), 1'b0, 5'(16 + i), 5'd0, 5'd0, 2'd0, 8'd4, 1'b0, 1'b0), '0);
    end
    wait_drain();
    // Aligned, misaligned, page crossing, empty and misaligned
    mem_pair(VLE, 2'd2, 8'd16, 32'h0000_1000);
    mem_pair(VLE, 2'd2, 8'd16, 32'h0000_1002);
    mem_pair(VSE, 2'd3, 8'd2, 32'h0000_1ff8);
    mem_pair(VSE, 2'd1, 8'd0, 32'h0000_0003);
    wait_drain();
    // Random chains on v0..v3, the last one an ALU op
    for (int i = 0; i < RandN; i++) begin
      r  = $urandom % 10;
      op = (r < 7 || i == RandN - 1) ? 4'(r % 4) : ((r < 9) ? VLE : VSE);
      send(pack_insn(op, 1'($urandom), 5'($urandom % 4), 5'($urandom % 4),
                     5'($urandom % 4), 2'($urandom), 8'($urandom % 24),
                     1'($urandom), 1'($urandom)),
           $urandom % 32'h2000);
    end
    wait_drain();

    if (issues_seen != sent_cnt || retires_seen != issues_seen) begin
      errors++;
      $display("Issued or retired count does not match the instructions sent");
    end
    if (max_running < 2) begin
      errors++;
      $display("No two instructions were running at the same time");
    end
    if (!b2b_seen) begin
      errors++;
      $display("Independent instructions were never issued back to back");
    end
    print_summary();
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/vseq_pkg.sv
hdl/vinsn_decoder.sv
hdl/vinsn_sequencer.sv
hdl/vector_lane.sv
hdl/vaddr_checker.sv
hdl/vseq_top.sv
dv/tb_vseq.sv

//--- Bender.yml
package:
  name: vseq

sources:
  - hdl/vseq_pkg.sv
  - hdl/vinsn_decoder.sv
  - hdl/vinsn_sequencer.sv
  - hdl/vector_lane.sv
  - hdl/vaddr_checker.sv
  - hdl/vseq_top.sv
  - target: test
    files:
      - dv/tb_vseq.sv
